//--- hw/spiMemPkg.sv
//------------------------------------------------------------
// Shared sizes, enums and structs for the SPI slave memory
// Byte and address widths are fixed by the command format
//------------------------------------------------------------

package spiMemPkg;

  // Command byte is {address[6:0], readFlag}
  localparam int wordWidth = 8;
  localparam int addrWidth = 7;

  // Taken from bit 0 of the command byte
  typedef enum logic {
    opWrite = 1'b0,
    opRead  = 1'b1
  } spiOpcode;

  typedef enum logic [2:0] {
    stIdle      = 3'd0,
    stCommand   = 3'd1,
    stDecode    = 3'd2,
    stWriteData = 3'd3,
    stReadData  = 3'd4,
    stDone      = 3'd5
  } fsmState;

  // Conditioned pin activity, built at the top level
  typedef struct packed {
    logic sclkRise;   // One-cycle pulse
    logic sclkFall;   // One-cycle pulse
    logic csActive;   // High while selected
    logic csEnd;      // Pulse on CS deassert
    logic mosiBit;
  } pinEvents;

  // FSM to memory
  typedef struct packed {
    logic [addrWidth-1:0] address;
    logic [wordWidth-1:0] writeData;
    logic                 writeEnable;
  } memRequest;

endpackage

//--- hw/inputConditioner.sv
//------------------------------------------------------------
// Synchronizer, debounce filter and edge detect for one pin
// Edge pulses trail a clean input edge by 2 + waitTime + 1 cycles
// Glitches shorter than waitTime cycles are dropped
//------------------------------------------------------------
`timescale 1ns/1ps

module inputConditioner #(
  parameter int waitTime = 3
) (
  input  logic trigger,
  input  logic rst,
  input  logic noisy,
  output logic conditioned,
  output logic risingEdge,
  output logic fallingEdge
);

  localparam int cntWidth = (waitTime > 1) ? $clog2(waitTime) : 1;

  logic                syncFirst;
  logic                syncSecond;
  logic [cntWidth-1:0] stableCount;

  // Two-flop synchronizer
  always_ff @(posedge trigger) begin
    if (rst) begin
      syncFirst  <= 1'b0;
      syncSecond <= 1'b0;
    end else begin
      syncFirst  <= noisy;
      syncSecond <= syncFirst;
    end
  end

  // Accept a new level only once it has held long enough
  always_ff @(posedge trigger) begin
    if (rst) begin
      stableCount <= '0;
      conditioned <= 1'b0;
      risingEdge  <= 1'b0;
      fallingEdge <= 1'b0;
    end else begin
      risingEdge  <= 1'b0;   // Pulses last one cycle
      fallingEdge <= 1'b0;
      if (syncSecond == conditioned) begin
        stableCount <= '0;   // No pending change
      end else if (stableCount == cntWidth'(waitTime - 1)) begin
        stableCount <= '0;
        conditioned <= syncSecond;
        risingEdge  <= syncSecond;
        fallingEdge <= ~syncSecond;
      end else begin
        stableCount <= stableCount + 1'b1;
      end
    end
  end

endmodule

//--- hw/shiftRegister.sv
//------------------------------------------------------------
// 8-bit shift register, the result stage
// Shifts MOSI in on SCLK rise, MSB first
// MISO bit is re-registered on SCLK fall from bit 7
//------------------------------------------------------------
`timescale 1ns/1ps

module shiftRegister (
  input  logic                                trigger,
  input  logic                                rst,
  input  spiMemPkg::pinEvents                 events,
  input  logic                                parallelLoad,
  input  logic [spiMemPkg::wordWidth-1:0]     parallelIn,
  output logic [spiMemPkg::wordWidth-1:0]     parallelOut,
  output logic                                misoBit
);

  //------------------------------------------------------------
  // Shift path
  //------------------------------------------------------------

  // Load wins over a shift in the same cycle
  always_ff @(posedge trigger) begin
    if (parallelLoad) begin
      parallelOut <= parallelIn;
    end else if (events.sclkRise) begin
      parallelOut <= {parallelOut[spiMemPkg::wordWidth-2:0], events.mosiBit};
    end
  end

  //------------------------------------------------------------
  // MISO stage
  //------------------------------------------------------------

  // Mode 0 slave changes its output after the falling edge
  always_ff @(posedge trigger) begin
    if (rst) begin
      misoBit <= 1'b0;
    end else if (events.sclkFall) begin
      misoBit <= parallelOut[spiMemPkg::wordWidth-1];
    end
  end

endmodule

//--- hw/spiTransactionFsm.sv
//------------------------------------------------------------
// Transaction FSM, the decode stage
// One command byte then one data byte per CS window
// CS deassert returns to idle from any state
//------------------------------------------------------------
`timescale 1ns/1ps

module spiTransactionFsm (
  input  logic                            trigger,
  input  logic                            rst,
  input  spiMemPkg::pinEvents             events,
  input  logic [spiMemPkg::wordWidth-1:0] shiftData,
  output spiMemPkg::memRequest            request,
  output logic                            parallelLoad,
  output logic                            misoEnable
);

  spiMemPkg::fsmState              state;
  spiMemPkg::spiOpcode             opcode;
  spiMemPkg::spiOpcode             cmdOpcode;
  logic [2:0]                      bitCount;
  logic                            lastBit;
  logic                            writePending;
  logic [spiMemPkg::addrWidth-1:0] addressReg;

  // Fields of the command byte sitting in the shift register
  assign cmdOpcode = spiMemPkg::spiOpcode'(shiftData[0]);
  assign lastBit   = events.sclkRise && (bitCount == 3'd7);

  //------------------------------------------------------------
  // State and bit counter
  //------------------------------------------------------------

  always_ff @(posedge trigger) begin
    if (rst) begin
      state        <= spiMemPkg::stIdle;
      opcode       <= spiMemPkg::opWrite;
      bitCount     <= 3'd0;
      writePending <= 1'b0;
    end else begin
      writePending <= 1'b0;
      if (events.csEnd) begin
        // Abort or normal end
        state    <= spiMemPkg::stIdle;
        bitCount <= 3'd0;
      end else begin
        if (events.sclkRise) begin
          bitCount <= bitCount + 3'd1;   // Wraps after 8 bits
        end
        case (state)
          spiMemPkg::stIdle: begin
            bitCount <= 3'd0;
            if (events.csActive) begin
              state <= spiMemPkg::stCommand;
            end
          end
          spiMemPkg::stCommand: begin
            if (lastBit) begin
              state <= spiMemPkg::stDecode;
            end
          end
          spiMemPkg::stDecode: begin
            opcode <= cmdOpcode;
            if (cmdOpcode == spiMemPkg::opRead) begin
              state <= spiMemPkg::stReadData;
            end else begin
              state <= spiMemPkg::stWriteData;
            end
          end
          spiMemPkg::stWriteData: begin
            if (lastBit) begin
              writePending <= 1'b1;   // Byte lands in the register this edge
              state        <= spiMemPkg::stDone;
            end
          end
          spiMemPkg::stReadData: begin
            if (lastBit) begin
              state <= spiMemPkg::stDone;
            end
          end
          default: begin
            state <= state;   // stDone waits for CS to end
          end
        endcase
      end
    end
  end

  // Address latch
  always_ff @(posedge trigger) begin
    if (state == spiMemPkg::stDecode) begin
      addressReg <= shiftData[spiMemPkg::wordWidth-1:1];
    end
  end

  //------------------------------------------------------------
  // Memory and output control
  //------------------------------------------------------------

  always_comb begin
    // Bypass the latch so the read data is ready during decode
    if (state == spiMemPkg::stDecode) begin
      request.address = shiftData[spiMemPkg::wordWidth-1:1];
    end else begin
      request.address = addressReg;
    end
    request.writeData   = shiftData;
    request.writeEnable = writePending;
  end

  assign parallelLoad = (state == spiMemPkg::stDecode) && (cmdOpcode == spiMemPkg::opRead);

  // Keep driving the last read bit until CS goes away
  assign misoEnable = (state == spiMemPkg::stReadData) ||
                      ((state == spiMemPkg::stDone) && (opcode == spiMemPkg::opRead));

endmodule

//--- hw/dataMemory.sv
//------------------------------------------------------------
// 128 x 8 register array, the execute stage
// Contents are undefined until written
//------------------------------------------------------------
`timescale 1ns/1ps

module dataMemory (
  input  logic                            trigger,
  input  spiMemPkg::memRequest            request,
  output logic [spiMemPkg::wordWidth-1:0] readData
);

  localparam int depth = 2 ** spiMemPkg::addrWidth;

  logic [spiMemPkg::wordWidth-1:0] memArray [depth];

  //------------------------------------------------------------
  // Write port
  //------------------------------------------------------------

  always_ff @(posedge trigger) begin
    if (request.writeEnable) begin
      memArray[request.address] <= request.writeData;
    end
  end

  //------------------------------------------------------------
  // Read port
  //------------------------------------------------------------

  // Asynchronous read so a load can happen in the decode cycle
  assign readData = memArray[request.address];

endmodule

//--- hw/spiMemory.sv
//------------------------------------------------------------
// SPI mode 0 slave memory, 128 bytes
// Each SCLK phase must last more than waitTime + 4 cycles
// MISO is a data bit plus enable with no pad here
//------------------------------------------------------------
`timescale 1ns/1ps

module spiMemory #(
  parameter int waitTime = 3
) (
  input  logic trigger,
  input  logic rst,
  input  logic sclk,
  input  logic csN,
  input  logic mosi,
  output logic misoBit,
  output logic misoEnable
);

  logic sclkRise;
  logic sclkFall;
  logic csSelected;
  logic csRelease;
  logic mosiLevel;

  spiMemPkg::pinEvents             events;
  spiMemPkg::memRequest            request;
  logic [spiMemPkg::wordWidth-1:0] shiftData;
  logic [spiMemPkg::wordWidth-1:0] readData;
  logic                            parallelLoad;

  //------------------------------------------------------------
  // Pin conditioning
  //------------------------------------------------------------

  inputConditioner #(.waitTime(waitTime)) sclkCond (
    .trigger     (trigger),
    .rst         (rst),
    .noisy       (sclk),
    .conditioned (),
    .risingEdge  (sclkRise),
    .fallingEdge (sclkFall)
  );

  inputConditioner #(.waitTime(waitTime)) mosiCond (
    .trigger     (trigger),
    .rst         (rst),
    .noisy       (mosi),
    .conditioned (mosiLevel),
    .risingEdge  (),
    .fallingEdge ()
  );

  // Active-high select so the reset state is deselected
  inputConditioner #(.waitTime(waitTime)) csCond (
    .trigger     (trigger),
    .rst         (rst),
    .noisy       (~csN),
    .conditioned (csSelected),
    .risingEdge  (),
    .fallingEdge (csRelease)   // Deassert of an active-low select
  );

  assign events.sclkRise = sclkRise;
  assign events.sclkFall = sclkFall;
  assign events.csActive = csSelected;
  assign events.csEnd    = csRelease;
  assign events.mosiBit  = mosiLevel;

  //------------------------------------------------------------
  // Datapath and control
  //------------------------------------------------------------

  shiftRegister shifter (
    .trigger      (trigger),
    .rst          (rst),
    .events       (events),
    .parallelLoad (parallelLoad),
    .parallelIn   (readData),
    .parallelOut  (shiftData),
    .misoBit      (misoBit)
  );

  spiTransactionFsm fsm (
    .trigger      (trigger),
    .rst          (rst),
    .events       (events),
    .shiftData    (shiftData),
    .request      (request),
    .parallelLoad (parallelLoad),
    .misoEnable   (misoEnable)
  );

  dataMemory memory (
    .trigger  (trigger),
    .request  (request),
    .readData (readData)
  );

endmodule

//--- sim/spiMemory_assertions.sv
//------------------------------------------------------------
// Protocol assertions, bound into the SPI slave top level
// CS is watched after conditioning, so its latency is excluded
//------------------------------------------------------------
`timescale 1ns/1ps

module spiMemory_assertions (
  input logic                 trigger,
  input logic                 rst,
  input logic                 misoEnable,
  input spiMemPkg::pinEvents  events,
  input spiMemPkg::memRequest request
);

  // FSM leaves its read states one cycle after csEnd
  property misoQuietWhenDeselected;
    @(posedge trigger) disable iff (rst)
      (!events.csActive && $past(!events.csActive)) |-> !misoEnable;
  endproperty

  property writeSingleCycle;
    @(posedge trigger) disable iff (rst)
      $rose(request.writeEnable) |=> !request.writeEnable;
  endproperty

  property sclkEdgesExclusive;
    @(posedge trigger) disable iff (rst)
      !(events.sclkRise && events.sclkFall);
  endproperty

  misoQuietCheck: assert property (misoQuietWhenDeselected)
    else $error("MISO enabled while chip select is deasserted");
  writePulseCheck: assert property (writeSingleCycle)
    else $error("Memory write enable held longer than one cycle");
  sclkEdgeCheck: assert property (sclkEdgesExclusive)
    else $error("SCLK rise and fall pulses seen in the same cycle");

endmodule

bind spiMemory spiMemory_assertions assertChecks (
  .trigger    (trigger),
  .rst        (rst),
  .misoEnable (misoEnable),
  .events     (events),
  .request    (request)
);

//--- sim/spiMemoryTb.sv
//------------------------------------------------------------
// Table-driven testbench for the SPI slave memory
// Host model runs mode 0 with 20-cycle SCLK phases
// Reads only hit addresses that an earlier entry wrote
//------------------------------------------------------------
`timescale 1ns/1ps

module spiMemoryTb #(
  parameter int waitTime = 3,
  parameter int randSeed = 32'h366bd2c4
);

  localparam int phase = 20;   // trigger cycles per SCLK phase

  // One row of the stimulus table
  typedef struct packed {
    logic                            isRead;
    logic [spiMemPkg::addrWidth-1:0] address;
    logic [spiMemPkg::wordWidth-1:0] data;
    logic [spiMemPkg::wordWidth-1:0] expected;
    logic                            abort;
  } testEntry;

  logic trigger;
  logic rst;
  logic sclk;
  logic csN;
  logic mosi;
  logic misoBit;
  logic misoEnable;

  testEntry                        testTable[$];
  logic [spiMemPkg::wordWidth-1:0] model [2 ** spiMemPkg::addrWidth];
  int                              seed;
  int                              errorCount = 0;
  int                              checkCount = 0;
  bit                              tableReady = 1'b0;

  spiMemory #(.waitTime(waitTime)) u_dut (
    .trigger    (trigger),
    .rst        (rst),
    .sclk       (sclk),
    .csN        (csN),
    .mosi       (mosi),
    .misoBit    (misoBit),
    .misoEnable (misoEnable)
  );

  initial begin
    trigger = 1'b0;
    forever #5 trigger = ~trigger;
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------

  task automatic waitCycles(input int count);
    repeat (count) @(posedge trigger);
  endtask

  task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED @ %0t ns: %s, got 0x%02h, expected 0x%02h",
               $time, what, actual, expected);
    end
  endtask

  // Appends a row and keeps the reference model in step
  task automatic addEntry(input logic isRead, input logic [6:0] addr, input logic abort);
    testEntry entry;
    entry.isRead   = isRead;
    entry.address  = addr;
    entry.abort    = abort;
    entry.expected = model[addr];
    if (isRead) begin
      entry.data = 8'h00;
    end else if (abort) begin
      entry.data = ~model[addr];   // Any landing write would show up
    end else begin
      entry.data     = 8'($random(seed));
      model[addr]    = entry.data;
      entry.expected = entry.data;
    end
    testTable.push_back(entry);
  endtask

  task automatic buildTable();
    addEntry(1'b0, 7'd5, 1'b0);     // Round trip
    addEntry(1'b1, 7'd5, 1'b0);
    addEntry(1'b0, 7'd0, 1'b0);     // Independent addresses
    addEntry(1'b0, 7'd127, 1'b0);
    addEntry(1'b0, 7'd42, 1'b0);
    addEntry(1'b0, 7'd85, 1'b0);
    addEntry(1'b1, 7'd127, 1'b0);
    addEntry(1'b1, 7'd0, 1'b0);
    addEntry(1'b1, 7'd85, 1'b0);
    addEntry(1'b1, 7'd42, 1'b0);
    addEntry(1'b0, 7'd42, 1'b0);    // Overwrite
    addEntry(1'b1, 7'd42, 1'b0);
    addEntry(1'b0, 7'd16, 1'b0);
    addEntry(1'b0, 7'd16, 1'b1);    // Aborted after 4 data bits
    addEntry(1'b1, 7'd16, 1'b0);
    addEntry(1'b1, 7'd0, 1'b0);
  endtask

  //------------------------------------------------------------
  // SPI host model, mode 0
  //------------------------------------------------------------

  task automatic spiTransfer(input logic [7:0] cmd, input logic [7:0] dataOut,
                             input logic abort, output logic [7:0] dataIn);
    logic [15:0] frame;
    int          nBits;
    logic        expectEnable;
    frame  = {cmd, dataOut};
    nBits  = abort ? 12 : 16;
    dataIn = 8'h00;
    @(posedge trigger);
    csN  <= 1'b0;
    mosi <= frame[15];
    for (int i = 0; i < nBits; i++) begin
      waitCycles(phase);
      // Sample just before the rising edge
      expectEnable = (i >= 8) && cmd[0];
      checkValue({7'd0, misoEnable}, {7'd0, expectEnable},
                 (i < 8) ? "MISO enable in command byte" : "MISO enable in data byte");
      if (i >= 8) begin
        dataIn = {dataIn[6:0], misoBit};
      end
      sclk <= 1'b1;
      waitCycles(phase);
      sclk <= 1'b0;
      if (i < 15) begin
        mosi <= frame[14 - i];
      end
    end
    waitCycles(phase);
    csN  <= 1'b1;
    mosi <= 1'b0;
    waitCycles(2 * phase);
    checkValue({7'd0, misoEnable}, 8'd0, "MISO enable between transactions");
  endtask

  task automatic runEntry(input int index, input testEntry entry);
    logic [7:0] readBack;
    int         errorsBefore;
    string      opName;
    errorsBefore = errorCount;
    spiTransfer({entry.address, entry.isRead}, entry.data, entry.abort, readBack);
    if (entry.isRead) begin
      opName = "read";
      checkValue(readBack, entry.expected, $sformatf("read data at address %0d", entry.address));
    end else if (entry.abort) begin
      opName = "aborted write";
    end else begin
      opName = "write";
    end
    $display("Test %0d: %s at address %0d, data 0x%02h: %s", index, opName, entry.address,
             entry.isRead ? readBack : entry.data, (errorCount == errorsBefore) ? "ok" : "error");
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------

  initial begin
    rst  = 1'b1;
    sclk = 1'b0;
    csN  = 1'b1;
    mosi = 1'b0;
    seed = randSeed;
    buildTable();
    tableReady = 1'b1;
    waitCycles(4);
    rst <= 1'b0;
    waitCycles(1);
    checkValue({7'd0, misoEnable}, 8'd0, "MISO enable after reset");
    waitCycles(3 * phase);   // Conditioners settle on the idle pin levels
    for (int i = 0; i < testTable.size(); i++) begin
      runEntry(i, testTable[i]);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", testTable.size(), checkCount,
             errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Budget is twice the host time for full 16-bit frames
  initial begin : watchdog
    wait (tableReady);
    repeat (testTable.size() * 16 * 40 * 2) @(posedge trigger);
    $display("Timeout: the run did not finish in the expected number of clock cycles");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- filelist.f
hw/spiMemPkg.sv
hw/inputConditioner.sv
hw/shiftRegister.sv
hw/spiTransactionFsm.sv
hw/dataMemory.sv
hw/spiMemory.sv
sim/spiMemory_assertions.sv
sim/spiMemoryTb.sv

//--- Makefile
# Verilator build and run for the SPI slave memory testbench
# Override on the command line, e.g. make run WAIT_TIME=4 SEED=12345

TOP       ?= spiMemoryTb
WAIT_TIME ?= 3
# Decimal form of 32'h366bd2c4
SEED      ?= 913035972
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' filelist.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a listed source or the list itself changes
$(BIN): $(SRCS) filelist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GwaitTime=$(WAIT_TIME) \
		-GrandSeed=$(SEED) --Mdir $(OBJ_DIR) -f filelist.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
